// File: posit_settings.svh
// format constants for the 16-bit, es=1 posit divider
// include wherever a field width or saturation bound is needed

`ifndef POSIT_SETTINGS_SVH
`define POSIT_SETTINGS_SVH

// word and exponent field
`define POSIT_N 16                  // posit word width
`define POSIT_ES 1                  // exponent bits

// derived widths
`define POSIT_RS ($clog2(`POSIT_N))                  // regime count width
`define POSIT_SW (`POSIT_RS + `POSIT_ES + 3)         // signed scale width

// saturation bound, regime of maxpos
`define POSIT_MAXK (`POSIT_N - 2)

`endif

// File: posit_pkg.sv
// shared types for the posit divider pipeline
// every stage imports this and passes one struct to the next

`include "posit_settings.svh"

package posit_pkg;

  //////////////////////////////////////////////////
  // raw word
  //////////////////////////////////////////////////
  typedef logic [`POSIT_N-1:0] positWord_t;

  // not-a-real, sign bit alone
  localparam positWord_t NarWord = {1'b1, {(`POSIT_N-1){1'b0}}};

  //////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                      sign;
    logic                      nar;
    logic                      zero;
    logic signed [`POSIT_RS:0] k;         // regime value
    logic [`POSIT_ES-1:0]      exponent;
    logic [`POSIT_N-1:0]       mant;      // hidden one at msb
  } decodedPosit_t;

  typedef struct packed {
    decodedPosit_t a;                     // dividend
    decodedPosit_t b;                     // divisor
    logic          valid;
  } operandPair_t;

  typedef struct packed {
    logic                        sign;
    logic                        nar;
    logic                        zero;
    logic signed [`POSIT_SW-1:0] scale;   // k * 2^es + e
    logic [2*`POSIT_N-1:0]       mant;    // normalised, sticky in lsb
    logic                        valid;
  } quotient_t;

  typedef struct packed {
    positWord_t word;
    logic       overflow;
    logic       underflow;
    logic       valid;
  } positResult_t;

endpackage

// File: posit_decode.sv
// input stage of the divider
// splits both raw posits into sign, regime, exponent and mantissa, one cycle

`timescale 1ns/100ps
`include "posit_settings.svh"

module posit_decode (
  input  logic                   clk,
  input  logic                   rstN,
  input  posit_pkg::positWord_t  opA,
  input  posit_pkg::positWord_t  opB,
  input  logic                   inValid,
  output posit_pkg::operandPair_t operands
);

  import posit_pkg::*;

  //////////////////////////////////////////////////
  // field extraction for one word
  //////////////////////////////////////////////////
  function automatic decodedPosit_t decodeOne(positWord_t w);
    decodedPosit_t       d;
    positWord_t          mag;
    logic [`POSIT_N-2:0] body;
    logic [`POSIT_N-2:0] rest;
    logic                regBit;
    logic                runDone;
    int                  runLen;

    d.sign = w[`POSIT_N-1];
    d.nar  = (w == NarWord);
    d.zero = (w == '0);
    mag    = d.sign ? -w : w;              // work on the magnitude
    body   = mag[`POSIT_N-2:0];
    regBit = body[`POSIT_N-2];             // first regime bit sets the run polarity

    // leading-run detector
    runLen  = 0;
    runDone = 1'b0;
    for (int i = `POSIT_N-2; i >= 0; i--) begin
      if (!runDone && body[i] == regBit) begin
        runLen++;
      end else begin
        runDone = 1'b1;
      end
    end

    // ones run gives k = m-1, zeros run gives k = -m
    d.k = (`POSIT_RS+1)'(regBit ? runLen - 1 : -runLen);

    // drop run and terminator so zeros fill the cut-off bits
    rest       = body << (runLen + 1);
    d.exponent = rest[`POSIT_N-2 -: `POSIT_ES];
    d.mant     = {1'b1, rest[`POSIT_N-2-`POSIT_ES:0], {`POSIT_ES{1'b0}}};
    return d;
  endfunction

  //////////////////////////////////////////////////
  // operand register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    operands.a     <= decodeOne(opA);
    operands.b     <= decodeOne(opB);
    operands.valid <= inValid;
    if (!rstN) begin
      operands.valid <= 1'b0;
    end
  end

  // regime of every real operand stays inside the maxpos bound
  assertRegimeRange: assert property (@(posedge clk) disable iff (!rstN)
    operands.valid |->
      (operands.a.zero || operands.a.nar ||
        (operands.a.k >= -`POSIT_MAXK && operands.a.k <= `POSIT_MAXK)) &&
      (operands.b.zero || operands.b.nar ||
        (operands.b.k >= -`POSIT_MAXK && operands.b.k <= `POSIT_MAXK)));

endmodule

// File: posit_div.sv
// middle stage of the divider
// divides the mantissas, subtracts the scales and normalises the quotient
// combinational core, registered at the output, one cycle

`timescale 1ns/100ps
`include "posit_settings.svh"

module posit_div (
  input  logic                    clk,
  input  logic                    rstN,
  input  posit_pkg::operandPair_t operands,
  output posit_pkg::quotient_t    quotient
);

  import posit_pkg::*;

  localparam int N = `POSIT_N;

  logic [3*N-1:0]              dividend;   // mantA shifted up by 2N
  logic [3*N-1:0]              divisor;
  logic [3*N-1:0]              quo;
  logic                        remNz;      // anything left over
  logic [2*N-1:0]              normMant;
  logic signed [`POSIT_SW-1:0] kDiff;
  logic signed [`POSIT_SW-1:0] expDiff;
  quotient_t                   qNext;

  //////////////////////////////////////////////////
  // mantissa division
  //////////////////////////////////////////////////
  // hidden one is always set by decode, even for zero and NaR,
  // so the divisor never reads as 0
  always_comb begin
    dividend = {operands.a.mant, {(2*N){1'b0}}};
    divisor  = {{(2*N){1'b0}}, operands.b.mant};
    quo      = dividend / divisor;
    remNz    = |(dividend % divisor);
  end

  //////////////////////////////////////////////////
  // normalise and build scale
  //////////////////////////////////////////////////
  always_comb begin
    expDiff = $signed({1'b0, operands.a.exponent}) - $signed({1'b0, operands.b.exponent});
    kDiff   = operands.a.k - operands.b.k;

    // ratio of two [1,2) mantissas lies in (0.5,2)
    if (quo[2*N]) begin
      normMant = {quo[2*N:2], |quo[1:0] | remNz};      // ratio >= 1
    end else begin
      normMant = {quo[2*N-1:1], quo[0] | remNz};       // ratio < 1, one bit up
      expDiff  = expDiff - 1;                          // and pay for it here
    end

    qNext.sign  = operands.a.sign ^ operands.b.sign;
    qNext.nar   = operands.a.nar | operands.b.nar | operands.b.zero;   // x/0 is NaR too
    qNext.zero  = operands.a.zero & ~qNext.nar;
    qNext.scale = (kDiff <<< `POSIT_ES) + expDiff;
    qNext.mant  = normMant;
    qNext.valid = operands.valid;
  end

  //////////////////////////////////////////////////
  // quotient register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    quotient <= qNext;
    if (!rstN) begin
      quotient.valid <= 1'b0;
    end
  end

  // normalisation leaves the leading one in place for real results
  assertQuoNorm: assert property (@(posedge clk) disable iff (!rstN)
    quotient.valid && !quotient.nar && !quotient.zero |-> quotient.mant[2*N-1]);

endmodule

// File: posit_encode.sv
// output stage of the divider
// packs the quotient into a posit word, round to nearest even, saturating
// at maxpos / minpos with overflow and underflow flags, one cycle

`timescale 1ns/100ps
`include "posit_settings.svh"

module posit_encode (
  input  logic                    clk,
  input  logic                    rstN,
  input  posit_pkg::quotient_t    quotient,
  output posit_pkg::positResult_t result
);

  import posit_pkg::*;

  localparam int N        = `POSIT_N;
  localparam int ZW       = 3*N + `POSIT_ES;              // regime+exp+frac+pad
  localparam int MaxScale = `POSIT_MAXK << `POSIT_ES;     // scale of maxpos

  logic signed [`POSIT_SW-1:0] kOut;
  logic [`POSIT_ES-1:0]        eOut;
  int                          runLen;
  logic signed [ZW-1:0]        zSeed;
  logic signed [ZW-1:0]        zShift;
  logic [N-2:0]                body;
  logic                        guardBit;
  logic                        roundBit;
  logic                        stickyBit;
  logic                        roundUp;
  logic                        ovf;
  logic                        unf;
  positWord_t                  mag;
  positResult_t                rNext;

  //////////////////////////////////////////////////
  // regime run and rounding
  //////////////////////////////////////////////////
  always_comb begin
    kOut   = quotient.scale >>> `POSIT_ES;               // floor
    eOut   = quotient.scale[`POSIT_ES-1:0];
    runLen = (kOut >= 0) ? kOut + 1 : -kOut;

    // seed is r, ~r, exp, fraction; the arithmetic shift copies r in front
    zSeed  = {~kOut[`POSIT_SW-1], kOut[`POSIT_SW-1], eOut,
              quotient.mant[2*N-2:0], {(N-1){1'b0}}};
    zShift = zSeed >>> (runLen - 1);

    body      = zShift[ZW-1 -: N-1];
    guardBit  = zShift[ZW-N];
    roundBit  = zShift[ZW-N-1];
    stickyBit = |zShift[ZW-N-2:0];
    roundUp   = guardBit & (roundBit | stickyBit | body[0]);   // ties to even

    ovf = quotient.scale > MaxScale;
    unf = quotient.scale < -MaxScale;

    // carry may ripple into the regime but maxpos itself never rounds up
    if (ovf) begin
      mag = {1'b0, {(N-1){1'b1}}};
    end else if (unf) begin
      mag = positWord_t'(1);                            // minpos so never zero
    end else begin
      mag = {1'b0, body} + positWord_t'(roundUp);
    end
  end

  //////////////////////////////////////////////////
  // sign and specials
  //////////////////////////////////////////////////
  always_comb begin
    rNext.word      = quotient.sign ? -mag : mag;
    rNext.overflow  = quotient.valid & ~quotient.nar & ~quotient.zero & ovf;
    rNext.underflow = quotient.valid & ~quotient.nar & ~quotient.zero & unf;
    rNext.valid     = quotient.valid;
    if (quotient.nar) begin
      rNext.word = NarWord;
    end else if (quotient.zero) begin
      rNext.word = '0;
    end
  end

  always_ff @(posedge clk) begin
    result <= rNext;
    if (!rstN) begin
      result.overflow  <= 1'b0;
      result.underflow <= 1'b0;
      result.valid     <= 1'b0;
    end
  end

  // a real quotient never packs to zero or NaR
  assertRealWord: assert property (@(posedge clk) disable iff (!rstN)
    quotient.valid && !quotient.nar && !quotient.zero |=>
      result.word != NarWord && result.word != '0);

  // saturation flags only mark real results
  assertFlagsReal: assert property (@(posedge clk) disable iff (!rstN)
    result.valid && (result.word == NarWord || result.word == '0) |->
      !result.overflow && !result.underflow);

endmodule

// File: posit_div_top.sv
// top of the three-stage posit divider, decode / divide / encode
// fixed 3-cycle latency, one division accepted every cycle

`timescale 1ns/100ps
`include "posit_settings.svh"

module posit_div_top (
  input  logic                  clk,
  input  logic                  rstN,
  input  posit_pkg::positWord_t opA,        // dividend
  input  posit_pkg::positWord_t opB,        // divisor
  input  logic                  inValid,
  output posit_pkg::positWord_t result,
  output logic                  overflow,
  output logic                  underflow,
  output logic                  outValid
);

  import posit_pkg::*;

  operandPair_t operands;   // decode -> div
  quotient_t    quotient;   // div -> encode
  positResult_t res;

  posit_decode i_decode (
    .clk      (clk),
    .rstN     (rstN),
    .opA      (opA),
    .opB      (opB),
    .inValid  (inValid),
    .operands (operands)
  );

  posit_div i_div (
    .clk      (clk),
    .rstN     (rstN),
    .operands (operands),
    .quotient (quotient)
  );

  posit_encode i_encode (
    .clk      (clk),
    .rstN     (rstN),
    .quotient (quotient),
    .result   (res)
  );

  // split the result struct onto the ports
  assign result    = res.word;
  assign overflow  = res.overflow;
  assign underflow = res.underflow;
  assign outValid  = res.valid;

endmodule

// File: tb_posit_div.sv
// testbench for the pipelined 16-bit posit divider
// table entries and random pairs are issued back to back, results checked in order

`timescale 1ns/100ps
`include "posit_settings.svh"

module tb_posit_div;

  import posit_pkg::*;

  localparam int NumEntries = 15;
  localparam int NumRandom  = 200;
  localparam int Latency    = 3;                  // drive edge to result cycle
  localparam int WatchdogNs = (NumEntries + NumRandom + 20) * 10;

  typedef struct packed {
    positWord_t a;
    positWord_t b;
    positWord_t res;
    logic       ovf;
    logic       unf;
  } stimEntry_t;

  typedef struct {
    logic       isRand;                           // only the sign is known
    int         idx;
    positWord_t a;
    positWord_t b;
    positWord_t res;
    logic       ovf;
    logic       unf;
    longint     dueCycle;
  } expItem_t;

  // dividend, divisor, quotient, overflow, underflow
  localparam stimEntry_t StimTable [NumEntries] = '{
    '{16'h5000, 16'h4000, 16'h5000, 1'b0, 1'b0},   // 2 / 1
    '{16'h4000, 16'h5000, 16'h3000, 1'b0, 1'b0},   // 1 / 2
    '{16'h4000, 16'hC000, 16'hC000, 1'b0, 1'b0},   // 1 / -1
    '{16'h5000, 16'h5000, 16'h4000, 1'b0, 1'b0},   // 2 / 2
    '{16'h4000, 16'h5800, 16'h2555, 1'b0, 1'b0},   // 1 / 3, rounded
    '{16'h4000, 16'h0000, 16'h8000, 1'b0, 1'b0},   // x / 0
    '{16'hC000, 16'h0000, 16'h8000, 1'b0, 1'b0},
    '{16'h0000, 16'h0000, 16'h8000, 1'b0, 1'b0},
    '{16'h8000, 16'h4000, 16'h8000, 1'b0, 1'b0},   // NaR / x
    '{16'h8000, 16'h0000, 16'h8000, 1'b0, 1'b0},
    '{16'h0000, 16'h4000, 16'h0000, 1'b0, 1'b0},   // 0 / x
    '{16'h0000, 16'hC000, 16'h0000, 1'b0, 1'b0},
    '{16'h7FFF, 16'h0001, 16'h7FFF, 1'b1, 1'b0},   // maxpos / minpos
    '{16'h0001, 16'h7FFF, 16'h0001, 1'b0, 1'b1},   // minpos / maxpos
    '{16'h8001, 16'h0001, 16'h8001, 1'b1, 1'b0}    // -maxpos / minpos
  };

  logic       clk = 1'b0;
  logic       rstN;
  positWord_t opA;
  positWord_t opB;
  logic       inValid;
  positWord_t result;
  logic       overflow;
  logic       underflow;
  logic       outValid;

  expItem_t   expQ[$];                            // in-flight expectations
  expItem_t   item;
  longint     cycleCnt = 0;

  posit_div_top i_dut (
    .clk       (clk),
    .rstN      (rstN),
    .opA       (opA),
    .opB       (opB),
    .inValid   (inValid),
    .result    (result),
    .overflow  (overflow),
    .underflow (underflow),
    .outValid  (outValid)
  );

  always #5 clk = ~clk;
  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  //////////////////////////////////////////////////
  // failure handling and compares
  //////////////////////////////////////////////////
  task automatic failRun();
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(string name, positWord_t act, positWord_t exp);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      failRun();
    end
  endtask

  task automatic checkFlag(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      failRun();
    end
  endtask

  task automatic checkCycle(string name, longint act, longint exp);
    if (act != exp) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
      failRun();
    end
  endtask

  // any word except zero and NaR
  function automatic positWord_t pickOperand();
    positWord_t w;
    do begin
      w = positWord_t'($urandom);
    end while (w == '0 || w == NarWord);
    return w;
  endfunction

  // drive one division now, expect it Latency cycles later
  task automatic issueDivision(expItem_t e);
    opA        = e.a;
    opB        = e.b;
    inValid    = 1'b1;
    e.dueCycle = cycleCnt + Latency;
    expQ.push_back(e);
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // output monitor, mid-cycle sampling
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstN !== 1'b1) begin
      checkFlag("outValid in reset", outValid, 1'b0);
    end else if (outValid === 1'b1) begin
      if (expQ.size() == 0) begin
        $display("outValid went high with no division in flight at %0t", $time);
        failRun();
      end else begin
        item = expQ.pop_front();
        checkCycle($sformatf("latency[%0d]", item.idx), cycleCnt, item.dueCycle);
        if (item.isRand) begin
          checkFlag($sformatf("result sign[%0d]", item.idx), result[`POSIT_N-1],
                    item.a[`POSIT_N-1] ^ item.b[`POSIT_N-1]);
          if (result == '0 || result == NarWord) begin
            $display("random division %0d gave zero or NaR for %h / %h", item.idx,
                     item.a, item.b);
            failRun();
          end
        end else begin
          checkWord($sformatf("result[%0d]", item.idx), result, item.res);
          checkFlag($sformatf("overflow[%0d]", item.idx), overflow, item.ovf);
          checkFlag($sformatf("underflow[%0d]", item.idx), underflow, item.unf);
        end
      end
    end else if (outValid !== 1'b0) begin
      $display("outValid is unknown at %0t", $time);
      failRun();
    end else if (expQ.size() != 0 && expQ[0].dueCycle < cycleCnt) begin
      $display("result %0d did not come out on its cycle", expQ[0].idx);
      failRun();
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    expItem_t e;
    void'($urandom(32'h162a_6745));
    rstN    = 1'b0;
    inValid = 1'b0;
    opA     = '0;
    opB     = '0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;

    for (int i = 0; i < NumEntries; i++) begin    // directed table, back to back
      e.isRand = 1'b0;
      e.idx    = i;
      e.a      = StimTable[i].a;
      e.b      = StimTable[i].b;
      e.res    = StimTable[i].res;
      e.ovf    = StimTable[i].ovf;
      e.unf    = StimTable[i].unf;
      issueDivision(e);
    end
    for (int i = 0; i < NumRandom; i++) begin
      e.isRand = 1'b1;
      e.idx    = NumEntries + i;
      e.a      = pickOperand();
      e.b      = pickOperand();
      e.res    = '0;
      e.ovf    = 1'b0;
      e.unf    = 1'b0;
      issueDivision(e);
    end
    inValid = 1'b0;

    while (expQ.size() != 0) @(negedge clk);     // drain the pipeline
    repeat (2) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

  // bound on the whole run
  initial begin
    #(WatchdogNs);
    $display("timeout, outValid never arrived for %0d pending divisions", expQ.size());
    failRun();
  end

endmodule

// File: all.f
+incdir+.
posit_pkg.sv
posit_decode.sv
posit_div.sv
posit_encode.sv
posit_div_top.sv
tb_posit_div.sv

// File: Bender.yml
package:
  name: posit_div

sources:
  - include_dirs:
      - .
    files:
      - posit_pkg.sv
      - posit_decode.sv
      - posit_div.sv
      - posit_encode.sv
      - posit_div_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_posit_div.sv
